//--- testbench/ipic_stimulus.txt
# Command letter then hex arguments, several commands may share a line
# W addr data | R addr expect | L lines | S cycles | Q irq | X rounds
# Reset state, reserved and write-only addresses
R 0 10  R 2 0  R 3 0  Q 0
W 1 ffffffff  R 1 0  R 4 0  R 5 0
# ICSR readback across IDX values
W 6 3  W 7 6  R 6 3  R 7 3306  W 7 0  R 7 3300
W 6 a  W 7 a  S 5  R 7 a30b  W 7 0  S 5  R 7 a300
W 6 f  W 7 4  R 7 f304  W 7 0  R 7 f300
# Level interrupt on line 5
W 6 5  W 7 2  L 20  S 5  R 2 20  Q 1  R 7 5303
W 2 20  S 1  R 2 20  W 7 3  S 1  R 2 20
L 0  S 5  R 2 0  Q 0  W 7 0
# Edge interrupt on line 7
W 6 7  W 7 6  L 80  S 2  L 0  S 5  R 2 80  Q 1
W 2 80  R 2 0  Q 0  W 7 0
# Service and nesting on lines 9, 12 and 2
W 6 9  W 7 6  W 6 c  W 7 6  W 6 2  W 7 6
L 1200  S 2  L 0  S 5  R 2 1200  Q 1
W 5 0  R 0 9  R 3 200  R 2 1000  Q 0
W 6 9  R 7 9316
L 4  S 2  L 0  S 5  R 2 1004  Q 1
W 5 0  R 0 2  R 3 204  R 2 1000  Q 0
W 4 0  R 0 9  R 3 200  Q 0
W 4 0  R 0 10  R 3 0  Q 1
W 5 0  R 0 c  R 2 0  W 4 0  R 0 10  R 3 0  Q 0
W 6 9  W 7 0  W 6 c  W 7 0  W 6 2  W 7 0
# Inversion on line 4
W 6 4  W 7 a  S 5  R 2 10  Q 1
L 10  S 5  R 2 0  Q 0
L 0  W 7 0  S 5  R 2 0  Q 0
# Random level patterns with random inversion
X 20

//--- flist.f
+incdir+hdl
hdl/ipic_pkg.sv
hdl/ipic_line_detect.sv
hdl/ipic_prio_find.sv
hdl/ipic_regs.sv
hdl/ipic_service.sv
hdl/ipic_top.sv
testbench/ipic_assertions.sv
testbench/tb_ipic.sv

//--- Makefile
TOP := tb_ipic

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run $(TOP)"
	@echo "make clean  remove obj_dir"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf obj_dir

//--- testbench/tb_ipic.sv
// IPIC testbench
// Command file interpreter, random level phase and final report

`timescale 1ns/10ps
`default_nettype none

`include "ipic_settings.svh"

module tb_ipic;

    localparam int CLK_HALF    = 10;        // 20 ns period
    localparam int DRIVE_DLY   = 2;         // Input skew after posedge
    localparam int RST_CYCLES  = 16;
    localparam int IRQ_TIMEOUT = 20;        // Cycles
    localparam int MAX_CMDS    = 2000;      // Upper bound on file commands

    logic                clk;
    logic                rst_n;
    ipic_pkg::irq_vec_t  irq_lines;
    logic                csr_rd_req;
    logic                csr_wr_req;
    ipic_pkg::csr_addr_t csr_addr;
    ipic_pkg::csr_data_t csr_wdata;
    ipic_pkg::csr_data_t csr_rdata;
    logic                irq;

    int mismatches;
    int timeouts;
    int file_errors;

    ipic_top ipic_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .irq_lines_i  (irq_lines),
        .csr_rd_req_i (csr_rd_req),
        .csr_wr_req_i (csr_wr_req),
        .csr_addr_i   (csr_addr),
        .csr_wdata_i  (csr_wdata),
        .csr_rdata_o  (csr_rdata),
        .irq_o        (irq)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // ----------------------------------------
    // Bus and timing helpers

    // Next drive point, just after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic idle(input int n);
        for (int i = 0; i < n; i++) begin
            next_cycle();
        end
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp,
                            input string what);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH at %0d ns: %s, got 0x%08h expected 0x%08h",
                     $time, what, got, exp);
        end
    endtask

    // Single-cycle write, lands on the next edge
    task automatic csr_write(input ipic_pkg::csr_addr_t addr, input ipic_pkg::csr_data_t data);
        csr_wr_req = 1'b1;
        csr_addr   = addr;
        csr_wdata  = data;
        next_cycle();
        csr_wr_req = 1'b0;
    endtask

    task automatic csr_read(input ipic_pkg::csr_addr_t addr, output ipic_pkg::csr_data_t data);
        csr_rd_req = 1'b1;
        csr_addr   = addr;
        @(negedge clk);                 // Combinational data settled mid-cycle
        data = csr_rdata;
        next_cycle();
        csr_rd_req = 1'b0;
    endtask

    task automatic wait_irq(input logic exp);
        bit hit;
        hit = 1'b0;
        for (int n = 0; n < IRQ_TIMEOUT && !hit; n++) begin
            @(negedge clk);
            hit = (irq === exp);
            next_cycle();
        end
        if (!hit) begin
            timeouts++;
            $display("TIMEOUT at %0d ns: irq_o did not go to %0b within %0d cycles",
                     $time, exp, IRQ_TIMEOUT);
        end
    endtask

    // ----------------------------------------
    // Command file helpers

    // Comment runs to end of line
    task automatic skip_line(input int fd);
        int ch;
        ch = 0;
        for (int n = 0; n < 256 && ch != "\n" && ch != -1; n++) begin
            ch = $fgetc(fd);
        end
    endtask

    task automatic fetch_args(input int fd, input int n, output logic [31:0] a,
                              output logic [31:0] b, output bit ok);
        int code;
        b = '0;
        if (n == 2) code = $fscanf(fd, " %h %h", a, b);
        else        code = $fscanf(fd, " %h", a);
        ok = (code == n);
        if (!ok) begin
            file_errors++;
            $display("ERROR: stimulus file has a command with missing arguments");
        end
    endtask

    // All lines enabled in level mode, pending must equal lines ^ inversion
    task automatic random_phase(input int rounds);
        logic [31:0]         rnd;
        ipic_pkg::irq_vec_t  inv;
        ipic_pkg::irq_vec_t  act;
        ipic_pkg::csr_data_t cfg;
        ipic_pkg::csr_data_t rd;
        rnd = $urandom;
        inv = rnd[15:0];
        for (int i = 0; i < `IPIC_LINES; i++) begin
            cfg = '0;
            cfg[`IPIC_ICSR_IE]  = 1'b1;
            cfg[`IPIC_ICSR_INV] = inv[i];
            csr_write(`IPIC_ADDR_IDX, i);
            csr_write(`IPIC_ADDR_ICSR, cfg);
        end
        for (int r = 0; r < rounds; r++) begin
            rnd = $urandom;
            irq_lines = rnd[15:0];
            act = rnd[15:0] ^ inv;      // Active level per line
            idle(5);                    // Sync plus pending register
            csr_read(`IPIC_ADDR_IPR, rd);
            check_eq(rd, {16'h0, act}, $sformatf("random round %0d IPR", r));
            wait_irq(|act);             // Nothing in service here
        end
    endtask

    // ----------------------------------------
    // Main sequence
    initial begin
        int                  fd;
        int                  code;
        int                  ncmd;
        int                  total;
        bit                  done;
        bit                  ok;
        logic [7:0]          cmd;
        logic [31:0]         arg_a;
        logic [31:0]         arg_b;
        ipic_pkg::csr_data_t rd;

        mismatches  = 0;
        timeouts    = 0;
        file_errors = 0;
        rst_n       = 1'b0;
        irq_lines   = '0;
        csr_rd_req  = 1'b0;
        csr_wr_req  = 1'b0;
        csr_addr    = '0;
        csr_wdata   = '0;
        void'($urandom(68034));

        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        fd = $fopen("testbench/ipic_stimulus.txt", "r");
        if (fd == 0) begin
            file_errors++;
            $display("ERROR: cannot open the stimulus file");
        end else begin
            done = 1'b0;
            for (ncmd = 0; ncmd < MAX_CMDS && !done; ncmd++) begin
                code = $fscanf(fd, " %c", cmd);
                ok   = 1'b1;
                if (code != 1) begin
                    done = 1'b1;        // End of file
                end else begin
                    case (cmd)
                        "#": skip_line(fd);
                        "W": begin
                            fetch_args(fd, 2, arg_a, arg_b, ok);
                            if (ok) csr_write(arg_a[2:0], arg_b);
                        end
                        "R": begin
                            fetch_args(fd, 2, arg_a, arg_b, ok);
                            if (ok) begin
                                csr_read(arg_a[2:0], rd);
                                check_eq(rd, arg_b, $sformatf("read addr %0d", arg_a[2:0]));
                            end
                        end
                        "L": begin
                            fetch_args(fd, 1, arg_a, arg_b, ok);
                            if (ok) irq_lines = arg_a[15:0];
                        end
                        "S": begin
                            fetch_args(fd, 1, arg_a, arg_b, ok);
                            if (ok) idle(arg_a);
                        end
                        "Q": begin
                            fetch_args(fd, 1, arg_a, arg_b, ok);
                            if (ok) wait_irq(arg_a[0]);
                        end
                        "X": begin
                            fetch_args(fd, 1, arg_a, arg_b, ok);
                            if (ok) random_phase(arg_a);
                        end
                        default: begin
                            ok = 1'b0;
                            file_errors++;
                            $display("ERROR: unknown command '%c' in the stimulus file", cmd);
                        end
                    endcase
                    if (!ok) done = 1'b1;
                end
            end
            if (!done) begin
                file_errors++;
                $display("ERROR: stimulus file longer than %0d commands", MAX_CMDS);
            end
            $fclose(fd);
        end

        total = mismatches + timeouts + file_errors
              + ipic_top_inst.u_service.service_asserts.assert_fails;
        $display("Errors: mismatches %0d, timeouts %0d, stimulus %0d, assertions %0d",
                 mismatches, timeouts, file_errors,
                 ipic_top_inst.u_service.service_asserts.assert_fails);
        if (total == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/ipic_assertions.sv
// Concurrent checks on the service block
// Request source and CISV/ISVR consistency, bound into ipic_service

`timescale 1ns/10ps
`default_nettype none

`include "ipic_settings.svh"

module ipic_assertions (
    input  logic                clk,
    input  logic                rst_n,
    input  ipic_pkg::irq_vec_t  ipr_i,
    input  ipic_pkg::irq_vec_t  ier_i,
    input  ipic_pkg::irq_vec_t  isvr_i,
    input  ipic_pkg::irq_vect_t cisv_i,
    input  logic                irq_i
);

    int                 assert_fails = 0;   // Failures so far
    ipic_pkg::irq_vec_t outrank;            // Lines ahead of CISV in priority

    // All lines when void, else those below the current vector
    always_comb begin
        for (int i = 0; i < `IPIC_LINES; i++) begin
            outrank[i] = (i < int'(cisv_i));
        end
    end

    // Request needs an enabled pending line that outranks the one in service
    irq_has_source: assert property (@(posedge clk) disable iff (!rst_n)
        irq_i |-> ((ipr_i & ier_i & outrank) != '0))
    else begin
        assert_fails++;
        $error("irq_o high with no enabled pending line above the one in service");
    end

    // Void vector exactly when nothing is in service
    void_matches_isvr: assert property (@(posedge clk) disable iff (!rst_n)
        (cisv_i == ipic_pkg::irq_vect_t'(`IPIC_VOID_VECT)) == (isvr_i == '0))
    else begin
        assert_fails++;
        $error("CISV void state disagrees with ISVR");
    end

    // CISV names the highest-priority line in service, never above 16
    cisv_is_top: assert property (@(posedge clk) disable iff (!rst_n)
        (cisv_i != ipic_pkg::irq_vect_t'(`IPIC_VOID_VECT)) |->
            (cisv_i < ipic_pkg::irq_vect_t'(`IPIC_VOID_VECT))
            && isvr_i[cisv_i[`IPIC_IDX_W-1:0]]
            && ((isvr_i & outrank) == '0))
    else begin
        assert_fails++;
        $error("CISV is not the highest-priority line in service");
    end

endmodule

bind ipic_service ipic_assertions service_asserts (
    .clk    (clk),
    .rst_n  (rst_n),
    .ipr_i  (ipr_i),
    .ier_i  (ier_i),
    .isvr_i (isvr_o),
    .cisv_i (cisv_o),
    .irq_i  (irq_o)
);

`default_nettype wire

//--- hdl/ipic_top.sv
// IPIC top level
// Line front end, register block and service block

`timescale 1ns/10ps
`default_nettype none

module ipic_top (
    input  logic                clk,
    input  logic                rst_n,
    input  ipic_pkg::irq_vec_t  irq_lines_i,    // External IRQ lines
    // CSR port
    input  logic                csr_rd_req_i,
    input  logic                csr_wr_req_i,
    input  ipic_pkg::csr_addr_t csr_addr_i,
    input  ipic_pkg::csr_data_t csr_wdata_i,
    output ipic_pkg::csr_data_t csr_rdata_o,
    output logic                irq_o           // Request to the core
);

    ipic_pkg::irq_vec_t  irq_lvl;
    ipic_pkg::irq_vec_t  irq_edge;
    ipic_pkg::irq_vec_t  iinv;
    ipic_pkg::irq_vec_t  ipr;
    ipic_pkg::irq_vec_t  ier;
    logic                soi_wr;
    logic                eoi_wr;
    logic                soi_take;
    ipic_pkg::irq_idx_t  req_idx;
    ipic_pkg::irq_vec_t  isvr;
    ipic_pkg::irq_vect_t cisv;

    // ----------------------------------------
    ipic_line_detect u_line_detect (
        .clk         (clk),
        .rst_n       (rst_n),
        .irq_lines_i (irq_lines_i),
        .iinv_i      (iinv),
        .irq_lvl_o   (irq_lvl),
        .irq_edge_o  (irq_edge)
    );

    ipic_regs u_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .csr_rd_req_i (csr_rd_req_i),
        .csr_wr_req_i (csr_wr_req_i),
        .csr_addr_i   (csr_addr_i),
        .csr_wdata_i  (csr_wdata_i),
        .csr_rdata_o  (csr_rdata_o),
        .irq_lvl_i    (irq_lvl),
        .irq_edge_i   (irq_edge),
        .iinv_o       (iinv),
        .ipr_o        (ipr),
        .ier_o        (ier),
        .soi_wr_o     (soi_wr),
        .eoi_wr_o     (eoi_wr),
        .soi_take_i   (soi_take),
        .req_idx_i    (req_idx),
        .isvr_i       (isvr),
        .cisv_i       (cisv)
    );

    ipic_service u_service (
        .clk        (clk),
        .rst_n      (rst_n),
        .ipr_i      (ipr),
        .ier_i      (ier),
        .soi_wr_i   (soi_wr),
        .eoi_wr_i   (eoi_wr),
        .soi_take_o (soi_take),
        .req_idx_o  (req_idx),
        .isvr_o     (isvr),
        .cisv_o     (cisv),
        .irq_o      (irq_o)
    );

endmodule

`default_nettype wire

//--- hdl/ipic_service.sv
// Interrupt service tracking
// ISVR, CISV, SOI/EOI handling and the request to the core

`timescale 1ns/10ps
`default_nettype none

`include "ipic_settings.svh"

module ipic_service (
    input  logic                clk,
    input  logic                rst_n,
    input  ipic_pkg::irq_vec_t  ipr_i,
    input  ipic_pkg::irq_vec_t  ier_i,
    input  logic                soi_wr_i,
    input  logic                eoi_wr_i,
    output logic                soi_take_o,     // SOI with a request present
    output ipic_pkg::irq_idx_t  req_idx_o,
    output ipic_pkg::irq_vec_t  isvr_o,
    output ipic_pkg::irq_vect_t cisv_o,
    output logic                irq_o           // To the core, M-mode external
);

    ipic_pkg::irq_vec_t  req_v;         // Pending and enabled
    logic                req_vld;
    ipic_pkg::irq_idx_t  req_idx;
    ipic_pkg::irq_vec_t  isvr_q;
    ipic_pkg::irq_vec_t  isvr_eoi;      // ISVR with current line dropped
    logic                eoi_vld;
    ipic_pkg::irq_idx_t  eoi_idx;       // Next CISV after EOI
    ipic_pkg::irq_vect_t cisv_q;
    logic                serv_vld;
    ipic_pkg::irq_idx_t  serv_idx;
    logic                irq_req;
    logic                start;
    logic                finish;

    assign req_v = ipr_i & ier_i;

    ipic_prio_find u_req_find (
        .vec_i (req_v),
        .vld_o (req_vld),
        .idx_o (req_idx)
    );

    // Current line, void when MSB set
    assign serv_vld = ~cisv_q[`IPIC_VECT_W-1];
    assign serv_idx = cisv_q[`IPIC_IDX_W-1:0];

    always_comb begin
        isvr_eoi = isvr_q;
        if (serv_vld) isvr_eoi[serv_idx] = 1'b0;
    end

    ipic_prio_find u_eoi_find (
        .vec_i (isvr_eoi),
        .vld_o (eoi_vld),
        .idx_o (eoi_idx)
    );

    // ----------------------------------------
    // Request and service control

    // Only a lower index may preempt
    assign irq_req    = req_vld & (~serv_vld | (req_idx < serv_idx));
    assign soi_take_o = soi_wr_i & req_vld;
    assign start      = soi_take_o & irq_req;
    assign finish     = eoi_wr_i & serv_vld;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            isvr_q <= '0;
            cisv_q <= ipic_pkg::irq_vect_t'(`IPIC_VOID_VECT);
        end else if (start) begin
            isvr_q[req_idx] <= 1'b1;
            cisv_q          <= {1'b0, req_idx};     // Nest over current
        end else if (finish) begin
            isvr_q <= isvr_eoi;
            cisv_q <= eoi_vld ? {1'b0, eoi_idx}     // Back to outer level
                              : ipic_pkg::irq_vect_t'(`IPIC_VOID_VECT);
        end
    end

    assign req_idx_o = req_idx;
    assign isvr_o    = isvr_q;
    assign cisv_o    = cisv_q;
    assign irq_o     = irq_req;

endmodule

`default_nettype wire

//--- hdl/ipic_regs.sv
// IPIC register block
// CSR decode and read mux, IDX/IER/IMR/IINVR/IPR registers

`timescale 1ns/10ps
`default_nettype none

`include "ipic_settings.svh"

module ipic_regs (
    input  logic                clk,
    input  logic                rst_n,
    // CSR port
    input  logic                csr_rd_req_i,
    input  logic                csr_wr_req_i,
    input  ipic_pkg::csr_addr_t csr_addr_i,
    input  ipic_pkg::csr_data_t csr_wdata_i,
    output ipic_pkg::csr_data_t csr_rdata_o,    // Same-cycle read data
    // Line front end
    input  ipic_pkg::irq_vec_t  irq_lvl_i,
    input  ipic_pkg::irq_vec_t  irq_edge_i,
    output ipic_pkg::irq_vec_t  iinv_o,
    // Service block
    output ipic_pkg::irq_vec_t  ipr_o,
    output ipic_pkg::irq_vec_t  ier_o,
    output logic                soi_wr_o,
    output logic                eoi_wr_o,
    input  logic                soi_take_i,     // SOI found a request
    input  ipic_pkg::irq_idx_t  req_idx_i,
    input  ipic_pkg::irq_vec_t  isvr_i,
    input  ipic_pkg::irq_vect_t cisv_i
);

    logic               idx_wr;
    logic               ipr_wr;
    logic               icsr_wr;
    ipic_pkg::irq_idx_t idx_q;          // ICSR line select
    ipic_pkg::irq_vec_t ier_q, ier_next;
    ipic_pkg::irq_vec_t imr_q, imr_next;    // 1 = edge mode
    ipic_pkg::irq_vec_t iinv_q, iinv_next;
    ipic_pkg::irq_vec_t ipr_q, ipr_next;
    ipic_pkg::irq_vec_t ipr_clr_req;    // Software asks to clear
    ipic_pkg::irq_vec_t ipr_clr;        // Clear actually allowed

    // ----------------------------------------
    // Write decode
    always_comb begin
        idx_wr   = 1'b0;
        ipr_wr   = 1'b0;
        icsr_wr  = 1'b0;
        soi_wr_o = 1'b0;
        eoi_wr_o = 1'b0;
        if (csr_wr_req_i) begin
            case (csr_addr_i)
                `IPIC_ADDR_IPR:  ipr_wr   = 1'b1;
                `IPIC_ADDR_EOI:  eoi_wr_o = 1'b1;
                `IPIC_ADDR_SOI:  soi_wr_o = 1'b1;
                `IPIC_ADDR_IDX:  idx_wr   = 1'b1;
                `IPIC_ADDR_ICSR: icsr_wr  = 1'b1;
                default: ;                  // Read-only or reserved, ignored
            endcase
        end
    end

    // ----------------------------------------
    // Per-line config through ICSR
    always_comb begin
        ier_next  = ier_q;
        imr_next  = imr_q;
        iinv_next = iinv_q;
        if (icsr_wr) begin
            ier_next[idx_q]  = csr_wdata_i[`IPIC_ICSR_IE];
            imr_next[idx_q]  = csr_wdata_i[`IPIC_ICSR_IM];
            iinv_next[idx_q] = csr_wdata_i[`IPIC_ICSR_INV];
        end
    end

    // Pending clear sources, at most one per cycle
    always_comb begin
        ipr_clr_req = '0;
        if (ipr_wr) begin
            ipr_clr_req = csr_wdata_i[`IPIC_LINES-1:0];     // W1C
        end else if (icsr_wr) begin
            ipr_clr_req[idx_q] = csr_wdata_i[`IPIC_ICSR_IP];
        end else if (soi_take_i) begin
            ipr_clr_req[req_idx_i] = 1'b1;                  // Line taken into service
        end
    end

    // Active level lines cannot be cleared
    assign ipr_clr = ipr_clr_req & (~irq_lvl_i | imr_next);

    // Level mode follows the line, edge mode sticks
    always_comb begin
        for (int i = 0; i < `IPIC_LINES; i++) begin
            ipr_next[i] = ipr_clr[i] ? 1'b0
                        : !imr_q[i]  ? irq_lvl_i[i]
                        : ipr_q[i] | irq_edge_i[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx_q  <= '0;
            ier_q  <= '0;
            imr_q  <= '0;
            iinv_q <= '0;
            ipr_q  <= '0;
        end else begin
            if (idx_wr) idx_q <= csr_wdata_i[`IPIC_IDX_W-1:0];
            ier_q  <= ier_next;
            imr_q  <= imr_next;
            iinv_q <= iinv_next;
            ipr_q  <= ipr_next;
        end
    end

    assign iinv_o = iinv_next;  // Front end sees inversion a cycle early
    assign ipr_o  = ipr_q;
    assign ier_o  = ier_q;

    // ----------------------------------------
    // Read mux, zero when idle
    always_comb begin
        csr_rdata_o = '0;
        if (csr_rd_req_i) begin
            case (csr_addr_i)
                `IPIC_ADDR_CISV: csr_rdata_o[`IPIC_VECT_W-1:0] = cisv_i;
                `IPIC_ADDR_IPR:  csr_rdata_o[`IPIC_LINES-1:0]  = ipr_q;
                `IPIC_ADDR_ISVR: csr_rdata_o[`IPIC_LINES-1:0]  = isvr_i;
                `IPIC_ADDR_IDX:  csr_rdata_o[`IPIC_IDX_W-1:0]  = idx_q;
                `IPIC_ADDR_ICSR: begin
                    csr_rdata_o[`IPIC_ICSR_IP]  = ipr_q[idx_q];
                    csr_rdata_o[`IPIC_ICSR_IE]  = ier_q[idx_q];
                    csr_rdata_o[`IPIC_ICSR_IM]  = imr_q[idx_q];
                    csr_rdata_o[`IPIC_ICSR_INV] = iinv_q[idx_q];
                    csr_rdata_o[`IPIC_ICSR_IS]  = isvr_i[idx_q];
                    csr_rdata_o[`IPIC_ICSR_PRV_LSB +: `IPIC_ICSR_PRV_W] = `IPIC_PRV_M;
                    csr_rdata_o[`IPIC_ICSR_LN_LSB +: `IPIC_IDX_W]       = idx_q;
                end
                default: ;                  // EOI, SOI and reserved read zero
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/ipic_prio_find.sv
// Fixed-priority search, lowest set bit wins
// Built as a tree of pairwise reductions

`timescale 1ns/10ps
`default_nettype none

`include "ipic_settings.svh"

module ipic_prio_find (
    input  ipic_pkg::irq_vec_t vec_i,       // Request bits
    output logic               vld_o,       // Any bit set
    output ipic_pkg::irq_idx_t idx_o        // Lowest set bit
);

    localparam int LINES = `IPIC_LINES;

    always_comb begin
        logic [LINES-1:0]   node_vld;
        ipic_pkg::irq_idx_t node_idx [LINES];

        // Leaves carry their own line number
        for (int i = 0; i < LINES; i++) begin
            node_vld[i] = vec_i[i];
            node_idx[i] = ipic_pkg::irq_idx_t'(i);
        end

        // Halve the node count each level, left child first
        // Node k is rebuilt from 2k and 2k+1, done in place
        for (int w = LINES / 2; w >= 1; w = w / 2) begin
            for (int k = 0; k < w; k++) begin
                node_idx[k] = node_vld[2*k] ? node_idx[2*k] : node_idx[2*k+1];
                node_vld[k] = node_vld[2*k] | node_vld[2*k+1];
            end
        end

        // Root of the tree
        vld_o = node_vld[0];
        idx_o = node_idx[0];    // Meaningless when vld_o low
    end

endmodule

`default_nettype wire

//--- hdl/ipic_line_detect.sv
// IRQ line front end
// Two-flop synchronizer, inversion, level and edge detect

`timescale 1ns/10ps
`default_nettype none

module ipic_line_detect (
    input  logic               clk,
    input  logic               rst_n,
    input  ipic_pkg::irq_vec_t irq_lines_i,     // Raw async lines
    input  ipic_pkg::irq_vec_t iinv_i,          // Inversion, next value
    output ipic_pkg::irq_vec_t irq_lvl_o,       // Active level per line
    output ipic_pkg::irq_vec_t irq_edge_o       // Change into active level
);

    ipic_pkg::irq_vec_t sync_q;     // First sync stage
    ipic_pkg::irq_vec_t lines_q;    // Second sync stage, safe to use
    ipic_pkg::irq_vec_t dly_q;      // Previous synchronized value

    // ----------------------------------------
    // Synchronizer and delay stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q  <= '0;
            lines_q <= '0;
            dly_q   <= '0;
        end else begin
            sync_q  <= irq_lines_i;
            lines_q <= sync_q;
            dly_q   <= lines_q;     // One cycle behind for edge compare
        end
    end

    // ----------------------------------------
    // Detection

    // Level visible two cycles after the line moves
    assign irq_lvl_o = lines_q ^ iinv_i;

    // Any change that lands on the active level
    assign irq_edge_o = (dly_q ^ lines_q) & irq_lvl_o;

endmodule

`default_nettype wire

//--- hdl/ipic_pkg.sv
// IPIC shared vector types

`default_nettype none

`include "ipic_settings.svh"

package ipic_pkg;

    // ----------------------------------------
    // Per-line and index types

    // One bit per IRQ line
    typedef logic [`IPIC_LINES-1:0]  irq_vec_t;

    // Line number
    typedef logic [`IPIC_IDX_W-1:0]  irq_idx_t;

    // Vector number, top bit flags void
    typedef logic [`IPIC_VECT_W-1:0] irq_vect_t;

    // ----------------------------------------
    // CSR port types

    typedef logic [`IPIC_ADDR_W-1:0] csr_addr_t;    // Register select
    typedef logic [`IPIC_XLEN-1:0]   csr_data_t;    // Read/write data

endpackage

`default_nettype wire

//--- hdl/ipic_settings.svh
// IPIC build constants
// Line count, widths, CSR address map and ICSR bit layout

`ifndef IPIC_SETTINGS_SVH
`define IPIC_SETTINGS_SVH

// Sizes
`define IPIC_LINES          16          // IRQ lines served
`define IPIC_IDX_W          4           // Line index width
`define IPIC_VECT_W         5           // Vector number, MSB set only for void
`define IPIC_VOID_VECT      16          // Nothing in service
`define IPIC_XLEN           32          // CSR data width
`define IPIC_ADDR_W         3           // CSR address width

// ----------------------------------------
// CSR address map
`define IPIC_ADDR_CISV      3'd0        // Current vector in service, RO
`define IPIC_ADDR_CICSR     3'd1        // Reserved, reads zero
`define IPIC_ADDR_IPR       3'd2        // Pending, write 1 to clear
`define IPIC_ADDR_ISVR      3'd3        // In service, RO
`define IPIC_ADDR_EOI       3'd4        // End of interrupt, WO
`define IPIC_ADDR_SOI       3'd5        // Start of interrupt, WO
`define IPIC_ADDR_IDX       3'd6        // Line select for ICSR
`define IPIC_ADDR_ICSR      3'd7        // Control/status of indexed line

// ----------------------------------------
// ICSR bit positions
`define IPIC_ICSR_IP        0
`define IPIC_ICSR_IE        1
`define IPIC_ICSR_IM        2           // 0 level, 1 edge
`define IPIC_ICSR_INV       3
`define IPIC_ICSR_IS        4
`define IPIC_ICSR_PRV_LSB   8
`define IPIC_ICSR_PRV_W     2
`define IPIC_PRV_M          2'b11       // Machine mode only
`define IPIC_ICSR_LN_LSB    12

`endif
